/* csr_map_pkg.sv */
`default_nettype none

package csr_map_pkg;

    // ==========================================================
    // Basic CSR types
    // ==========================================================
    typedef logic [31:0] csr_word_t;
    typedef logic [11:0] csr_addr_t;

    // Encoding follows the funct3 low bits of the CSR instructions
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    // ==========================================================
    // CSR addresses
    // ==========================================================
    localparam csr_addr_t CSR_MSTATUS         = 12'h300;
    localparam csr_addr_t CSR_MIE             = 12'h304;
    localparam csr_addr_t CSR_MTVEC           = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH        = 12'h340;
    localparam csr_addr_t CSR_MEPC            = 12'h341;
    localparam csr_addr_t CSR_MCAUSE          = 12'h342;
    localparam csr_addr_t CSR_MTVAL           = 12'h343;
    localparam csr_addr_t CSR_MIP             = 12'h344;
    localparam csr_addr_t CSR_MCYCLE          = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET        = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH         = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH       = 12'hB82;
    localparam csr_addr_t CSR_CUSTOM_MTIME    = 12'hBC0;
    localparam csr_addr_t CSR_CUSTOM_MTIMECMP = 12'hBC1;
    // User read-only aliases of the machine counters
    localparam csr_addr_t CSR_CYCLE           = 12'hC00;
    localparam csr_addr_t CSR_INSTRET         = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH          = 12'hC80;
    localparam csr_addr_t CSR_INSTRETH        = 12'hC82;
    // Identity registers
    localparam csr_addr_t CSR_MVENDORID       = 12'hF11;
    localparam csr_addr_t CSR_MARCHID         = 12'hF12;
    localparam csr_addr_t CSR_MIMPID          = 12'hF13;
    localparam csr_addr_t CSR_MHARTID         = 12'hF14;

    // ==========================================================
    // One-hot write strobe layout
    // ==========================================================
    localparam int SEL_MSTATUS   = 0;
    localparam int SEL_MIE       = 1;
    localparam int SEL_MTVEC     = 2;
    localparam int SEL_MSCRATCH  = 3;
    localparam int SEL_MEPC      = 4;
    localparam int SEL_MCAUSE    = 5;
    localparam int SEL_MTVAL     = 6;
    localparam int SEL_MIP       = 7;
    localparam int SEL_MTIMECMP  = 8;
    localparam int SEL_MCYCLE    = 9;
    localparam int SEL_MCYCLEH   = 10;
    localparam int SEL_MINSTRET  = 11;
    localparam int SEL_MINSTRETH = 12;
    localparam int SEL_COUNT     = 13;

    typedef logic [SEL_COUNT-1:0] csr_sel_t;

    // Bit positions inside mstatus, mie and mip
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MIE_MTIE_BIT    = 7;
    localparam int MIP_MTIP_BIT    = 7;

endpackage

`default_nettype wire

/* csr_trap_pkg.sv */
`default_nettype none

package csr_trap_pkg;

    import csr_map_pkg::*;

    // ==========================================================
    // mcause codes
    // ==========================================================
    localparam csr_word_t CAUSE_ILLEGAL_INSTR = 32'h0000_0002;
    localparam csr_word_t CAUSE_BREAKPOINT    = 32'h0000_0003;
    localparam csr_word_t CAUSE_MISALIGNED    = 32'h0000_0004;
    localparam csr_word_t CAUSE_ILLEGAL_CSR   = 32'h0000_000B;
    // Machine timer with the interrupt bit set
    localparam csr_word_t CAUSE_TIMER_IRQ     = 32'h8000_0007;

    // ==========================================================
    // Fixed words loaded on timer trap entry and on mret
    // ==========================================================
    // Timer enable dropped, MIE moved into MPIE
    localparam csr_word_t TRAP_MIE_VALUE      = 32'h0000_0808;
    localparam csr_word_t TRAP_MSTATUS_VALUE  = 32'h0000_0080;

    // Timer enable back on, MIE restored
    localparam csr_word_t MRET_MIE_VALUE      = 32'h0000_0888;
    localparam csr_word_t MRET_MSTATUS_VALUE  = 32'h0000_0008;

endpackage

`default_nettype wire

/* csr_write_decode.sv */
`default_nettype none

module csr_write_decode
    import csr_map_pkg::*;
(
    input  logic      csr_wren,
    input  csr_addr_t csr_addr,
    input  csr_op_t   csr_op,
    input  logic      csr_imm_sel,
    input  csr_word_t csr_imm,
    input  csr_word_t csr_rs_data,
    input  csr_word_t addr_value,
    output csr_sel_t  wr_sel,
    output csr_word_t wr_data
);

    csr_word_t operand;
    csr_sel_t  addr_sel;

    assign operand = csr_imm_sel ? csr_imm : csr_rs_data;

    // Read-modify-write against the current value at csr_addr
    always_comb begin
        case (csr_op)
            CSR_OP_WRITE: wr_data = operand;
            CSR_OP_SET:   wr_data = addr_value | operand;
            CSR_OP_CLEAR: wr_data = addr_value & ~operand;
            CSR_OP_NONE:  wr_data = addr_value;
            default:      wr_data = addr_value;
        endcase
    end

    // Only writable registers get a strobe bit
    always_comb begin
        addr_sel = '0;
        case (csr_addr)
            CSR_MSTATUS:         addr_sel[SEL_MSTATUS]   = 1'b1;
            CSR_MIE:             addr_sel[SEL_MIE]       = 1'b1;
            CSR_MTVEC:           addr_sel[SEL_MTVEC]     = 1'b1;
            CSR_MSCRATCH:        addr_sel[SEL_MSCRATCH]  = 1'b1;
            CSR_MEPC:            addr_sel[SEL_MEPC]      = 1'b1;
            CSR_MCAUSE:          addr_sel[SEL_MCAUSE]    = 1'b1;
            CSR_MTVAL:           addr_sel[SEL_MTVAL]     = 1'b1;
            CSR_MIP:             addr_sel[SEL_MIP]       = 1'b1;
            CSR_CUSTOM_MTIMECMP: addr_sel[SEL_MTIMECMP]  = 1'b1;
            CSR_MCYCLE:          addr_sel[SEL_MCYCLE]    = 1'b1;
            CSR_MCYCLEH:         addr_sel[SEL_MCYCLEH]   = 1'b1;
            CSR_MINSTRET:        addr_sel[SEL_MINSTRET]  = 1'b1;
            CSR_MINSTRETH:       addr_sel[SEL_MINSTRETH] = 1'b1;
            default:             addr_sel = '0;
        endcase
    end

    assign wr_sel = (csr_wren && (csr_op != CSR_OP_NONE)) ? addr_sel : '0;

endmodule

`default_nettype wire

/* csr_counters.sv */
`default_nettype none

module csr_counters
    import csr_map_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_retired,
    input  csr_sel_t  wr_sel,
    input  csr_word_t wr_data,
    output csr_word_t mcycle,
    output csr_word_t mcycleh,
    output csr_word_t minstret,
    output csr_word_t minstreth,
    output csr_word_t mtime
);

    logic [63:0] cycle_nxt;
    logic [63:0] instret_nxt;

    // 64-bit step with carry into the high half, then software override
    function automatic logic [63:0] count_next(
        input csr_word_t lo,
        input csr_word_t hi,
        input logic      inc,
        input logic      wr_lo,
        input logic      wr_hi,
        input csr_word_t data
    );
        logic [63:0] nxt;
        nxt = {hi, lo} + {63'd0, inc};
        if (wr_lo) begin
            nxt[31:0] = data;
        end
        if (wr_hi) begin
            nxt[63:32] = data;
        end
        return nxt;
    endfunction

    assign cycle_nxt = count_next(mcycle, mcycleh, 1'b1,
                                  wr_sel[SEL_MCYCLE], wr_sel[SEL_MCYCLEH], wr_data);

    assign instret_nxt = count_next(minstret, minstreth, instr_retired,
                                    wr_sel[SEL_MINSTRET], wr_sel[SEL_MINSTRETH], wr_data);

    // ==========================================================
    // Counter registers
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcycle    <= '0;
            mcycleh   <= '0;
            minstret  <= '0;
            minstreth <= '0;
            mtime     <= '0;
        end else begin
            mcycle    <= cycle_nxt[31:0];
            mcycleh   <= cycle_nxt[63:32];
            minstret  <= instret_nxt[31:0];
            minstreth <= instret_nxt[63:32];
            // mtime is read-only, no write path
            mtime     <= mtime + 32'd1;
        end
    end

    // Free-running mcycle between software writes
    assert property (@(posedge clk) disable iff (!arst_n)
        ($past(arst_n) && !$past(wr_sel[SEL_MCYCLE]))
            |-> (mcycle == $past(mcycle) + 32'd1))
        else $error("mcycle did not step by one");

endmodule

`default_nettype wire

/* csr_machine_regs.sv */
`default_nettype none

module csr_machine_regs
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  csr_sel_t  wr_sel,
    input  csr_word_t wr_data,
    input  csr_word_t mtime,
    input  logic      exc_illegal_instr,
    input  logic      exc_misaligned,
    input  logic      exc_illegal_csr,
    input  logic      exc_breakpoint,
    input  logic      timer_irq_taken,
    input  logic      mret,
    input  csr_word_t trap_pc,
    input  csr_word_t trap_tval,
    output csr_word_t mstatus,
    output csr_word_t mie,
    output csr_word_t mtvec,
    output csr_word_t mscratch,
    output csr_word_t mepc,
    output csr_word_t mcause,
    output csr_word_t mtval,
    output csr_word_t mip,
    output csr_word_t mtimecmp,
    output logic      timer_irq,
    output logic      redirect_en,
    output csr_word_t redirect_pc
);

    logic      timer_hit;
    logic      exc_any;
    logic      trap_any;
    csr_word_t exc_cause;
    csr_word_t mstatus_nxt, mie_nxt, mtvec_nxt, mscratch_nxt, mepc_nxt;
    csr_word_t mcause_nxt, mtval_nxt, mip_nxt, mtimecmp_nxt;

    // Zero compare value means the timer is disarmed
    assign timer_hit = (mtime >= mtimecmp) && (mtime != '0) && (mtimecmp != '0);
    assign timer_irq = timer_hit && mstatus[MSTATUS_MIE_BIT] && mie[MIE_MTIE_BIT]
                       && !timer_irq_taken;

    assign exc_any  = exc_illegal_instr | exc_misaligned | exc_illegal_csr | exc_breakpoint;
    assign trap_any = exc_any | timer_irq_taken;

    assign redirect_en = trap_any | mret;
    assign redirect_pc = trap_any ? mtvec : mepc;

    // Later exception in the list wins
    always_comb begin
        exc_cause = CAUSE_ILLEGAL_INSTR;
        if (exc_misaligned)  exc_cause = CAUSE_MISALIGNED;
        if (exc_illegal_csr) exc_cause = CAUSE_ILLEGAL_CSR;
        if (exc_breakpoint)  exc_cause = CAUSE_BREAKPOINT;
    end

    // ==========================================================
    // Next state from hardware events and software writes
    // ==========================================================
    always_comb begin
        mstatus_nxt  = mstatus;
        mie_nxt      = mie;
        mtvec_nxt    = mtvec;
        mscratch_nxt = mscratch;
        mepc_nxt     = mepc;
        mcause_nxt   = mcause;
        mtval_nxt    = mtval;
        mip_nxt      = mip;
        mtimecmp_nxt = mtimecmp;

        if (timer_hit) begin
            mip_nxt = csr_word_t'(1) << MIP_MTIP_BIT;
        end
        if (exc_any) begin
            mcause_nxt = exc_cause;
            mepc_nxt   = trap_pc;
            mtval_nxt  = trap_tval;
        end
        if (timer_irq_taken) begin
            mcause_nxt  = CAUSE_TIMER_IRQ;
            mepc_nxt    = trap_pc;
            mie_nxt     = TRAP_MIE_VALUE;
            mstatus_nxt = TRAP_MSTATUS_VALUE;
        end
        if (mret) begin
            mie_nxt     = MRET_MIE_VALUE;
            mstatus_nxt = MRET_MSTATUS_VALUE;
            mip_nxt     = '0;
        end

        // Software has the last word
        if (wr_sel[SEL_MSTATUS])  mstatus_nxt  = wr_data;
        if (wr_sel[SEL_MIE])      mie_nxt      = wr_data;
        if (wr_sel[SEL_MTVEC])    mtvec_nxt    = wr_data;
        if (wr_sel[SEL_MSCRATCH]) mscratch_nxt = wr_data;
        if (wr_sel[SEL_MEPC])     mepc_nxt     = wr_data;
        if (wr_sel[SEL_MCAUSE])   mcause_nxt   = wr_data;
        if (wr_sel[SEL_MTVAL])    mtval_nxt    = wr_data;
        if (wr_sel[SEL_MIP])      mip_nxt      = wr_data;
        if (wr_sel[SEL_MTIMECMP]) mtimecmp_nxt = wr_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
            mtimecmp <= '0;
        end else begin
            mstatus  <= mstatus_nxt;
            mie      <= mie_nxt;
            mtvec    <= mtvec_nxt;
            mscratch <= mscratch_nxt;
            mepc     <= mepc_nxt;
            mcause   <= mcause_nxt;
            mtval    <= mtval_nxt;
            mip      <= mip_nxt;
            mtimecmp <= mtimecmp_nxt;
        end
    end

    // The core reports one exception per instruction
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({exc_illegal_instr, exc_misaligned, exc_illegal_csr, exc_breakpoint}))
        else $error("more than one exception flag raised");

endmodule

`default_nettype wire

/* csr_read_mux.sv */
`default_nettype none

module csr_read_mux
    import csr_map_pkg::*;
(
    input  logic      csr_rden,
    input  csr_addr_t csr_addr,
    input  csr_word_t mstatus,
    input  csr_word_t mie,
    input  csr_word_t mtvec,
    input  csr_word_t mscratch,
    input  csr_word_t mepc,
    input  csr_word_t mcause,
    input  csr_word_t mtval,
    input  csr_word_t mip,
    input  csr_word_t mtimecmp,
    input  csr_word_t mcycle,
    input  csr_word_t mcycleh,
    input  csr_word_t minstret,
    input  csr_word_t minstreth,
    input  csr_word_t mtime,
    output csr_word_t addr_value,
    output csr_word_t csr_read_data
);

    // Ungated lookup that also feeds set/clear in the write path
    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:               addr_value = mstatus;
            CSR_MIE:                   addr_value = mie;
            CSR_MTVEC:                 addr_value = mtvec;
            CSR_MSCRATCH:              addr_value = mscratch;
            CSR_MEPC:                  addr_value = mepc;
            CSR_MCAUSE:                addr_value = mcause;
            CSR_MTVAL:                 addr_value = mtval;
            CSR_MIP:                   addr_value = mip;
            CSR_CUSTOM_MTIME:          addr_value = mtime;
            CSR_CUSTOM_MTIMECMP:       addr_value = mtimecmp;
            // User aliases share the machine counters
            CSR_MCYCLE, CSR_CYCLE:     addr_value = mcycle;
            CSR_MCYCLEH, CSR_CYCLEH:   addr_value = mcycleh;
            CSR_MINSTRET, CSR_INSTRET: addr_value = minstret;
            CSR_MINSTRETH, CSR_INSTRETH: begin
                addr_value = minstreth;
            end
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
                addr_value = '0;
            end
            default:                   addr_value = '0;
        endcase
    end

    assign csr_read_data = csr_rden ? addr_value : '0;

endmodule

`default_nettype wire

/* csr_unit.sv */
`default_nettype none

module csr_unit
    import csr_map_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    // CSR instruction request
    input  logic      csr_wren,
    input  logic      csr_rden,
    input  csr_addr_t csr_addr,
    input  csr_op_t   csr_op,
    input  logic      csr_imm_sel,
    input  csr_word_t csr_imm,
    input  csr_word_t csr_rs_data,
    input  logic      instr_retired,
    // Trap events and context
    input  logic      exc_illegal_instr,
    input  logic      exc_misaligned,
    input  logic      exc_illegal_csr,
    input  logic      exc_breakpoint,
    input  logic      timer_irq_taken,
    input  logic      mret,
    input  csr_word_t trap_pc,
    input  csr_word_t trap_tval,
    // Back to the core
    output csr_word_t csr_read_data,
    output logic      timer_irq,
    output logic      redirect_en,
    output csr_word_t redirect_pc
);

    // ==========================================================
    // Internal nets
    // ==========================================================
    csr_word_t addr_value;
    csr_sel_t  wr_sel;
    csr_word_t wr_data;

    csr_word_t mcycle;
    csr_word_t mcycleh;
    csr_word_t minstret;
    csr_word_t minstreth;
    csr_word_t mtime;

    csr_word_t mstatus;
    csr_word_t mie;
    csr_word_t mtvec;
    csr_word_t mscratch;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;
    csr_word_t mip;
    csr_word_t mtimecmp;

    // Port names match the nets above one to one
    csr_write_decode u_write_decode (.*);

    csr_counters u_counters (.*);

    csr_machine_regs u_machine_regs (.*);

    csr_read_mux u_read_mux (.*);

endmodule

`default_nettype wire

/* csr_unit_tb_checks.svh */
`ifndef CSR_UNIT_TB_CHECKS_SVH
`define CSR_UNIT_TB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

// CSR word read back
task automatic check_word(input string what, input csr_word_t got, input csr_word_t exp);
    if (got === exp) begin
        pass_count++;
        $display("Pass %s: read 0x%08h", what, got);
    end else begin
        fail_count++;
        $display("Fail at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
endtask

// PC only matters when a redirect is expected
task automatic check_redirect(input string what, input logic got_en, input csr_word_t got_pc,
                              input logic exp_en, input csr_word_t exp_pc);
    if (got_en === exp_en && (!exp_en || got_pc === exp_pc)) begin
        pass_count++;
        $display("Pass %s: redirect_en %b pc 0x%08h", what, got_en, got_pc);
    end else begin
        fail_count++;
        $display("Fail at %0t ns: %s redirect_en %b pc 0x%08h, expected %b pc 0x%08h",
                 $time, what, got_en, got_pc, exp_en, exp_pc);
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got === exp) begin
        pass_count++;
        $display("Pass %s: timer_irq %b", what, got);
    end else begin
        fail_count++;
        $display("Fail at %0t ns: %s timer_irq %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

/* csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb
    import csr_map_pkg::*;
    import csr_trap_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [3:0] {
        K_IDLE, K_CSR, K_READ, K_READ_OFF, K_RETIRE,
        K_EXC_ILL, K_EXC_MIS, K_EXC_CSR, K_EXC_BRK,
        K_TAKEN, K_MRET, K_IRQ, K_QUIET
    } kind_t;

    // One table row per clock cycle
    typedef struct packed {
        kind_t     kind;
        csr_op_t   op;
        logic      imm;
        csr_addr_t addr;
        csr_word_t operand;
        csr_word_t aux;
        csr_word_t expected;
    } step_t;

    logic      clk;
    logic      arst_n;
    logic      csr_wren;
    logic      csr_rden;
    csr_addr_t csr_addr;
    csr_op_t   csr_op;
    logic      csr_imm_sel;
    csr_word_t csr_imm;
    csr_word_t csr_rs_data;
    logic      instr_retired;
    logic      exc_illegal_instr;
    logic      exc_misaligned;
    logic      exc_illegal_csr;
    logic      exc_breakpoint;
    logic      timer_irq_taken;
    logic      mret;
    csr_word_t trap_pc;
    csr_word_t trap_tval;
    csr_word_t csr_read_data;
    logic      timer_irq;
    logic      redirect_en;
    csr_word_t redirect_pc;

    step_t steps[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    `include "csr_unit_tb_checks.svh"

    csr_unit u_csr_unit (
        .clk               (clk),
        .arst_n            (arst_n),
        .csr_wren          (csr_wren),
        .csr_rden          (csr_rden),
        .csr_addr          (csr_addr),
        .csr_op            (csr_op),
        .csr_imm_sel       (csr_imm_sel),
        .csr_imm           (csr_imm),
        .csr_rs_data       (csr_rs_data),
        .instr_retired     (instr_retired),
        .exc_illegal_instr (exc_illegal_instr),
        .exc_misaligned    (exc_misaligned),
        .exc_illegal_csr   (exc_illegal_csr),
        .exc_breakpoint    (exc_breakpoint),
        .timer_irq_taken   (timer_irq_taken),
        .mret              (mret),
        .trap_pc           (trap_pc),
        .trap_tval         (trap_tval),
        .csr_read_data     (csr_read_data),
        .timer_irq         (timer_irq),
        .redirect_en       (redirect_en),
        .redirect_pc       (redirect_pc)
    );

    always #10 clk = ~clk;

    // Run limit known once the table is built
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ============================================================
    // Table building
    // ============================================================
    task automatic add_step(input kind_t kind, input csr_op_t op, input logic imm,
                            input csr_addr_t addr, input csr_word_t operand,
                            input csr_word_t aux, input csr_word_t expected);
        step_t s;
        s = '{kind, op, imm, addr, operand, aux, expected};
        steps.push_back(s);
    endtask

    task automatic csr_access(input csr_op_t op, input logic imm, input csr_addr_t addr,
                              input csr_word_t data);
        add_step(K_CSR, op, imm, addr, data, '0, '0);
    endtask

    task automatic read_expect(input csr_addr_t addr, input csr_word_t exp);
        add_step(K_READ, CSR_OP_NONE, 1'b0, addr, '0, '0, exp);
    endtask

    task automatic event_step(input kind_t kind, input csr_word_t pc, input csr_word_t tval,
                              input csr_word_t exp);
        add_step(kind, CSR_OP_NONE, 1'b0, '0, pc, tval, exp);
    endtask

    task automatic build_table();
        csr_word_t a, b, c, x, y, tvec, pc, tval, tpc, scratch;
        int        n_ret;
        kind_t     exc_kind [4] = '{K_EXC_ILL, K_EXC_MIS, K_EXC_CSR, K_EXC_BRK};
        csr_word_t exc_cause [4] = '{CAUSE_ILLEGAL_INSTR, CAUSE_MISALIGNED,
                                     CAUSE_ILLEGAL_CSR, CAUSE_BREAKPOINT};
        event_step(K_QUIET, '0, '0, '0);

        // Register operand on mscratch
        a = $urandom;
        b = $urandom;
        c = $urandom;
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MSCRATCH, a);
        read_expect(CSR_MSCRATCH, a);
        csr_access(CSR_OP_SET, 1'b0, CSR_MSCRATCH, b);
        read_expect(CSR_MSCRATCH, a | b);
        csr_access(CSR_OP_CLEAR, 1'b0, CSR_MSCRATCH, c);
        read_expect(CSR_MSCRATCH, (a | b) & ~c);
        // Zero-extended five-bit immediate
        a = $urandom & 32'h1f;
        b = $urandom & 32'h1f;
        c = $urandom & 32'h1f;
        scratch = (a | b) & ~c;
        csr_access(CSR_OP_WRITE, 1'b1, CSR_MSCRATCH, a);
        read_expect(CSR_MSCRATCH, a);
        csr_access(CSR_OP_SET, 1'b1, CSR_MSCRATCH, b);
        read_expect(CSR_MSCRATCH, a | b);
        csr_access(CSR_OP_CLEAR, 1'b1, CSR_MSCRATCH, c);
        read_expect(CSR_MSCRATCH, scratch);
        read_expect(12'h7C0, '0);
        // mtime is never zero here, so a gated read shows the gate
        add_step(K_READ_OFF, CSR_OP_NONE, 1'b0, CSR_CUSTOM_MTIME, '0, '0, '0);

        // mtime ignores writes and row i reads i + 1 edges since reset
        csr_access(CSR_OP_WRITE, 1'b0, CSR_CUSTOM_MTIME, '0);
        read_expect(CSR_CUSTOM_MTIME, csr_word_t'(steps.size() + 1));

        // ============================================================
        // Counters
        // ============================================================
        // Kept small so no carry reaches mcycleh before the wrap test
        x = $urandom & 32'h0fff_ffff;
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MCYCLE, x);
        read_expect(CSR_CYCLE, x);
        read_expect(CSR_MCYCLE, x + 32'd1);
        read_expect(CSR_CYCLE, x + 32'd2);
        y = $urandom & 32'h0fff_ffff;
        n_ret = 1 + int'($urandom % 8);
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MINSTRET, y);
        for (int n = 0; n < n_ret; n++) begin
            event_step(K_RETIRE, '0, '0, '0);
        end
        read_expect(CSR_MINSTRET, y + csr_word_t'(n_ret));
        read_expect(CSR_INSTRET, y + csr_word_t'(n_ret));
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MCYCLE, 32'hffff_ffff);
        event_step(K_IDLE, '0, '0, '0);
        read_expect(CSR_MCYCLEH, 32'd1);
        read_expect(CSR_CYCLEH, 32'd1);
        read_expect(CSR_MCYCLE, 32'd2);

        // Trap entry with one exception at a time
        tvec = $urandom & ~32'h3;
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MTVEC, tvec);
        for (int k = 0; k < 4; k++) begin
            pc = $urandom & ~32'h3;
            tval = $urandom;
            event_step(exc_kind[k], pc, tval, tvec);
            read_expect(CSR_MCAUSE, exc_cause[k]);
            read_expect(CSR_MEPC, pc);
            read_expect(CSR_MTVAL, tval);
        end

        // Timer arm, enable and take
        csr_access(CSR_OP_WRITE, 1'b0, CSR_CUSTOM_MTIMECMP, 32'd1);
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MIE, 32'd1 << MIE_MTIE_BIT);
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT);
        event_step(K_IRQ, '0, '0, 32'd1);
        read_expect(CSR_MIP, 32'd1 << MIP_MTIP_BIT);
        tpc = $urandom & ~32'h3;
        event_step(K_TAKEN, tpc, '0, tvec);
        read_expect(CSR_MCAUSE, CAUSE_TIMER_IRQ);
        read_expect(CSR_MEPC, tpc);
        read_expect(CSR_MIE, TRAP_MIE_VALUE);
        read_expect(CSR_MSTATUS, TRAP_MSTATUS_VALUE);
        event_step(K_IRQ, '0, '0, '0);

        // Disarm first so mip stays clear after mret
        csr_access(CSR_OP_WRITE, 1'b0, CSR_CUSTOM_MTIMECMP, '0);
        event_step(K_MRET, '0, '0, tpc);
        read_expect(CSR_MIP, '0);
        read_expect(CSR_MIE, MRET_MIE_VALUE);
        read_expect(CSR_MSTATUS, MRET_MSTATUS_VALUE);
        event_step(K_IRQ, '0, '0, '0);

        // Identity registers are read-only zero
        read_expect(CSR_MVENDORID, '0);
        read_expect(CSR_MARCHID, '0);
        read_expect(CSR_MIMPID, '0);
        read_expect(CSR_MHARTID, '0);
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MHARTID, $urandom);
        csr_access(CSR_OP_WRITE, 1'b0, CSR_MVENDORID, $urandom);
        read_expect(CSR_MHARTID, '0);
        read_expect(CSR_MVENDORID, '0);
        read_expect(CSR_MSCRATCH, scratch);
        event_step(K_QUIET, '0, '0, '0);
    endtask

    // ============================================================
    // Per-cycle drive and check
    // ============================================================
    task automatic drive_step(input step_t s);
        csr_wren          <= (s.kind == K_CSR);
        csr_rden          <= (s.kind == K_READ);
        csr_addr          <= s.addr;
        csr_op            <= (s.kind == K_CSR) ? s.op : CSR_OP_NONE;
        csr_imm_sel       <= s.imm;
        csr_imm           <= s.imm ? s.operand : '0;
        csr_rs_data       <= s.imm ? '0 : s.operand;
        instr_retired     <= (s.kind == K_RETIRE);
        exc_illegal_instr <= (s.kind == K_EXC_ILL);
        exc_misaligned    <= (s.kind == K_EXC_MIS);
        exc_illegal_csr   <= (s.kind == K_EXC_CSR);
        exc_breakpoint    <= (s.kind == K_EXC_BRK);
        timer_irq_taken   <= (s.kind == K_TAKEN);
        mret              <= (s.kind == K_MRET);
        trap_pc           <= s.operand;
        trap_tval         <= s.aux;
    endtask

    task automatic check_step(input int idx, input step_t s);
        string what;
        what = $sformatf("step %0d addr 0x%03h", idx, s.addr);
        case (s.kind)
            K_READ, K_READ_OFF: check_word(what, csr_read_data, s.expected);
            K_EXC_ILL, K_EXC_MIS, K_EXC_CSR, K_EXC_BRK, K_MRET: begin
                check_redirect(what, redirect_en, redirect_pc, 1'b1, s.expected);
            end
            // Request drops while the core takes it
            K_TAKEN: begin
                check_redirect(what, redirect_en, redirect_pc, 1'b1, s.expected);
                check_flag(what, timer_irq, 1'b0);
            end
            K_IRQ: check_flag(what, timer_irq, s.expected[0]);
            K_QUIET: begin
                check_redirect(what, redirect_en, redirect_pc, 1'b0, '0);
                check_flag(what, timer_irq, 1'b0);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        clk               = 1'b0;
        arst_n            = 1'b0;
        csr_wren          = 1'b0;
        csr_rden          = 1'b0;
        csr_addr          = '0;
        csr_op            = CSR_OP_NONE;
        csr_imm_sel       = 1'b0;
        csr_imm           = '0;
        csr_rs_data       = '0;
        instr_retired     = 1'b0;
        exc_illegal_instr = 1'b0;
        exc_misaligned    = 1'b0;
        exc_illegal_csr   = 1'b0;
        exc_breakpoint    = 1'b0;
        timer_irq_taken   = 1'b0;
        mret              = 1'b0;
        trap_pc           = '0;
        trap_tval         = '0;
        void'($urandom(32'hf05380b6));
        build_table();
        cycle_limit = steps.size() * 8 + 50;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Drive on the rising edge, sample on the falling edge
        foreach (steps[i]) begin
            @(posedge clk);
            drive_step(steps[i]);
            @(negedge clk);
            check_step(i, steps[i]);
        end
        @(posedge clk);

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
csr_map_pkg.sv
csr_trap_pkg.sv
csr_write_decode.sv
csr_counters.sv
csr_machine_regs.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_tb.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= csr_unit_tb
RTL_TOP    ?= csr_unit
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
